// File: hw/rv_exec_config.svh
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// data path and address width of the core.
`define RV_XLEN      32

// architectural registers, x0 included.
`define RV_NUM_REGS  32

`endif

// File: hw/rv_exec_pkg.sv
`include "rv_exec_config.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0]              xdata_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0]  reg_idx_t;

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic
    {
        OP1_REG,
        OP1_PC
    } op1_src_e;

    typedef enum logic [1:0]
    {
        OP2_REG,
        OP2_IMM_I,
        OP2_IMM_U,
        OP2_FOUR    // link value for jal and jalr.
    } op2_src_e;

    typedef struct packed
    {
        logic       valid;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        xdata_t     imm_i;
        xdata_t     imm_u;
        xdata_t     imm_pc;      // branch or jal offset.
        op1_src_e   op1_src;
        op2_src_e   op2_src;
        alu_op_e    alu_op;
        logic [2:0] funct3;
        logic       reg_write;
        logic       inst_jal;
        logic       inst_jalr;
        logic       inst_branch;
        xdata_t     pc;
    } decode_bus_t;

    typedef struct packed
    {
        logic       valid;
        xdata_t     op1;
        xdata_t     op2;
        xdata_t     reg_data1;   // compare inputs for branches.
        xdata_t     reg_data2;
        alu_op_e    alu_op;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic       reg_write;
        logic       inst_jump;
        logic       inst_branch;
        xdata_t     pc_target;
    } operand_bus_t;

    typedef struct packed
    {
        logic       valid;
        reg_idx_t   rd;
        xdata_t     data;
    } wb_bus_t;

endpackage

// File: hw/rv_decode.sv
`timescale 1ns/1ns

module rv_decode
(
    input  logic                       i_clk,
    input  logic                       i_arst_n,
    input  logic                       i_valid,
    input  logic [31:0]                i_instr,
    input  rv_exec_pkg::xdata_t        i_pc,
    output rv_exec_pkg::decode_bus_t   o_bus
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic                       funct7_alt;
    logic                       writes_rd;
    rv_exec_pkg::xdata_t        imm_b;
    rv_exec_pkg::xdata_t        imm_j;
    rv_exec_pkg::decode_bus_t   dec;
    rv_exec_pkg::decode_bus_t   bus_q;
    logic                       valid_q;

    // funct3 to alu function, sub only exists in the register form.
    function automatic rv_exec_pkg::alu_op_e alu_fn(input logic [2:0] f3,
                                                    input logic       alt,
                                                    input logic       is_reg);
        rv_exec_pkg::alu_op_e op;
        case (f3)
        3'b000:  op = (alt && is_reg) ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
        3'b001:  op = rv_exec_pkg::ALU_SLL;
        3'b010:  op = rv_exec_pkg::ALU_SLT;
        3'b011:  op = rv_exec_pkg::ALU_SLTU;
        3'b100:  op = rv_exec_pkg::ALU_XOR;
        3'b101:  op = alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
        3'b110:  op = rv_exec_pkg::ALU_OR;
        default: op = rv_exec_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode     = i_instr[6:0];
    assign funct3     = i_instr[14:12];
    assign funct7_alt = i_instr[30];

    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb
    begin
        dec         = '0;
        dec.rs1     = i_instr[19:15];
        dec.rs2     = i_instr[24:20];
        dec.rd      = i_instr[11:7];
        dec.imm_i   = {{20{i_instr[31]}}, i_instr[31:20]};
        dec.imm_u   = {i_instr[31:12], 12'b0};
        dec.imm_pc  = (opcode == OPC_JAL) ? imm_j : imm_b;
        dec.funct3  = funct3;
        dec.pc      = i_pc;
        dec.op1_src = rv_exec_pkg::OP1_REG;
        dec.op2_src = rv_exec_pkg::OP2_REG;
        dec.alu_op  = rv_exec_pkg::ALU_ADD;
        writes_rd   = 1'b0;
        case (opcode)
        OPC_OP:
        begin
            dec.alu_op = alu_fn(funct3, funct7_alt, 1'b1);
            writes_rd  = 1'b1;
        end
        OPC_OP_IMM:
        begin
            dec.alu_op  = alu_fn(funct3, funct7_alt, 1'b0);
            dec.op2_src = rv_exec_pkg::OP2_IMM_I;
            writes_rd   = 1'b1;
        end
        OPC_LUI:
        begin
            dec.rs1     = '0;   // x0 + imm_u.
            dec.op2_src = rv_exec_pkg::OP2_IMM_U;
            writes_rd   = 1'b1;
        end
        OPC_AUIPC:
        begin
            dec.op1_src = rv_exec_pkg::OP1_PC;
            dec.op2_src = rv_exec_pkg::OP2_IMM_U;
            writes_rd   = 1'b1;
        end
        OPC_JAL, OPC_JALR:
        begin
            dec.op1_src   = rv_exec_pkg::OP1_PC;
            dec.op2_src   = rv_exec_pkg::OP2_FOUR;
            dec.inst_jal  = (opcode == OPC_JAL);
            dec.inst_jalr = (opcode == OPC_JALR);
            writes_rd     = 1'b1;
        end
        OPC_BRANCH: dec.inst_branch = 1'b1;
        default: ;  // loads, stores, fence and system fall through as bubbles.
        endcase
        dec.reg_write = writes_rd && (dec.rd != '0);
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
            bus_q <= dec;
    end

    always_comb
    begin
        o_bus       = bus_q;
        o_bus.valid = valid_q;
    end

    a_write_xor_branch: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_bus.valid |-> !(o_bus.reg_write && o_bus.inst_branch));

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ns

`include "rv_exec_config.svh"

module rv_regfile
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  rv_exec_pkg::reg_idx_t   i_rd_addr1,
    input  rv_exec_pkg::reg_idx_t   i_rd_addr2,
    output rv_exec_pkg::xdata_t     o_rd_data1,
    output rv_exec_pkg::xdata_t     o_rd_data2,
    input  rv_exec_pkg::wb_bus_t    i_wb
);

    rv_exec_pkg::xdata_t regs [1:`RV_NUM_REGS-1];  // x0 has no storage.

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 1; i < `RV_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (i_wb.valid && (i_wb.rd != '0))
        begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // reads sample the array before this edge's write lands.
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_rd_data1 <= '0;
            o_rd_data2 <= '0;
        end
        else
        begin
            o_rd_data1 <= (i_rd_addr1 == '0) ? '0 : regs[i_rd_addr1];
            o_rd_data2 <= (i_rd_addr2 == '0) ? '0 : regs[i_rd_addr2];
        end
    end

    a_x0_port1: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_rd_addr1 == '0) |=> (o_rd_data1 == '0));
    a_x0_port2: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_rd_addr2 == '0) |=> (o_rd_data2 == '0));

endmodule

// File: hw/rv_operand.sv
`timescale 1ns/1ns

module rv_operand
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  rv_exec_pkg::decode_bus_t    i_bus,
    input  rv_exec_pkg::xdata_t         i_reg1_data,
    input  rv_exec_pkg::xdata_t         i_reg2_data,
    output rv_exec_pkg::operand_bus_t   o_bus
);

    rv_exec_pkg::decode_bus_t   dq;
    logic                       valid_q;
    rv_exec_pkg::xdata_t        reg_data1;
    rv_exec_pkg::xdata_t        reg_data2;
    rv_exec_pkg::xdata_t        op1;
    rv_exec_pkg::xdata_t        op2;
    rv_exec_pkg::xdata_t        jalr_sum;
    rv_exec_pkg::xdata_t        pc_target;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= i_bus.valid;
    end

    // register file data arrives on this same edge.
    always_ff @(posedge i_clk)
    begin
        if (i_bus.valid)
            dq <= i_bus;
    end

    assign reg_data1 = (|dq.rs1) ? i_reg1_data : '0;
    assign reg_data2 = (|dq.rs2) ? i_reg2_data : '0;

    always_comb
    begin
        case (dq.op1_src)
        rv_exec_pkg::OP1_PC: op1 = dq.pc;
        default:             op1 = reg_data1;
        endcase
    end

    always_comb
    begin
        case (dq.op2_src)
        rv_exec_pkg::OP2_REG:   op2 = reg_data2;
        rv_exec_pkg::OP2_IMM_I: op2 = dq.imm_i;
        rv_exec_pkg::OP2_IMM_U: op2 = dq.imm_u;
        default:                op2 = rv_exec_pkg::xdata_t'(4);
        endcase
    end

    assign jalr_sum = reg_data1 + dq.imm_i;

    always_comb
    begin
        if (dq.inst_jalr)
            pc_target = jalr_sum & ~rv_exec_pkg::xdata_t'(1);  // jalr drops bit 0.
        else
            pc_target = dq.pc + dq.imm_pc;
    end

    always_comb
    begin
        o_bus.valid       = valid_q;
        o_bus.op1         = op1;
        o_bus.op2         = op2;
        o_bus.reg_data1   = reg_data1;
        o_bus.reg_data2   = reg_data2;
        o_bus.alu_op      = dq.alu_op;
        o_bus.funct3      = dq.funct3;
        o_bus.rd          = dq.rd;
        o_bus.reg_write   = dq.reg_write;
        o_bus.inst_jump   = dq.inst_jal | dq.inst_jalr;
        o_bus.inst_branch = dq.inst_branch;
        o_bus.pc_target   = pc_target;
    end

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ns

module rv_alu
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  rv_exec_pkg::operand_bus_t   i_bus,
    output rv_exec_pkg::wb_bus_t        o_wb,
    output logic                        o_redirect,
    output rv_exec_pkg::xdata_t         o_redirect_pc
);

    rv_exec_pkg::xdata_t    result;
    logic [4:0]             shamt;
    logic                   taken;
    logic                   wb_valid_q;
    rv_exec_pkg::reg_idx_t  wb_rd_q;
    rv_exec_pkg::xdata_t    wb_data_q;
    logic                   redirect_q;
    rv_exec_pkg::xdata_t    redirect_pc_q;

    assign shamt = i_bus.op2[4:0];

    always_comb
    begin
        case (i_bus.alu_op)
        rv_exec_pkg::ALU_SUB:  result = i_bus.op1 - i_bus.op2;
        rv_exec_pkg::ALU_SLL:  result = i_bus.op1 << shamt;
        rv_exec_pkg::ALU_SLT:  result = rv_exec_pkg::xdata_t'($signed(i_bus.op1) <
                                                              $signed(i_bus.op2));
        rv_exec_pkg::ALU_SLTU: result = rv_exec_pkg::xdata_t'(i_bus.op1 < i_bus.op2);
        rv_exec_pkg::ALU_XOR:  result = i_bus.op1 ^ i_bus.op2;
        rv_exec_pkg::ALU_SRL:  result = i_bus.op1 >> shamt;
        rv_exec_pkg::ALU_SRA:  result = $signed(i_bus.op1) >>> shamt;
        rv_exec_pkg::ALU_OR:   result = i_bus.op1 | i_bus.op2;
        rv_exec_pkg::ALU_AND:  result = i_bus.op1 & i_bus.op2;
        default:               result = i_bus.op1 + i_bus.op2;
        endcase
    end

    // branch compare runs on the raw register values.
    always_comb
    begin
        case (i_bus.funct3)
        3'b000:  taken = (i_bus.reg_data1 == i_bus.reg_data2);
        3'b001:  taken = (i_bus.reg_data1 != i_bus.reg_data2);
        3'b100:  taken = ($signed(i_bus.reg_data1) <  $signed(i_bus.reg_data2));
        3'b101:  taken = ($signed(i_bus.reg_data1) >= $signed(i_bus.reg_data2));
        3'b110:  taken = (i_bus.reg_data1 <  i_bus.reg_data2);
        3'b111:  taken = (i_bus.reg_data1 >= i_bus.reg_data2);
        default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wb_valid_q <= 1'b0;
            redirect_q <= 1'b0;
        end
        else
        begin
            wb_valid_q <= i_bus.valid && i_bus.reg_write;
            redirect_q <= i_bus.valid && (i_bus.inst_jump || (i_bus.inst_branch && taken));
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_bus.valid)
        begin
            wb_rd_q       <= i_bus.rd;
            wb_data_q     <= result;
            redirect_pc_q <= i_bus.pc_target;
        end
    end

    assign o_wb.valid    = wb_valid_q;
    assign o_wb.rd       = wb_rd_q;
    assign o_wb.data     = wb_data_q;
    assign o_redirect    = redirect_q;
    assign o_redirect_pc = redirect_pc_q;

    // target comes from the operand stage adder.
    a_redirect_align: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_redirect |-> (o_redirect_pc[0] == 1'b0));

endmodule

// File: hw/rv_exec_top.sv
`timescale 1ns/1ns

module rv_exec_top
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_valid,
    input  logic [31:0]             i_instr,
    input  rv_exec_pkg::xdata_t     i_pc,
    output logic                    o_wb_valid,
    output rv_exec_pkg::reg_idx_t   o_wb_rd,
    output rv_exec_pkg::xdata_t     o_wb_data,
    output logic                    o_redirect,
    output rv_exec_pkg::xdata_t     o_redirect_pc
);

    rv_exec_pkg::decode_bus_t   dec_bus;
    rv_exec_pkg::operand_bus_t  opr_bus;
    rv_exec_pkg::wb_bus_t       wb_bus;
    rv_exec_pkg::xdata_t        reg1_data;
    rv_exec_pkg::xdata_t        reg2_data;

    rv_decode u_decode
    (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_valid(i_valid),
        .i_instr(i_instr),
        .i_pc(i_pc),
        .o_bus(dec_bus)
    );

    rv_regfile u_regfile
    (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_rd_addr1(dec_bus.rs1),
        .i_rd_addr2(dec_bus.rs2),
        .o_rd_data1(reg1_data),
        .o_rd_data2(reg2_data),
        .i_wb(wb_bus)   // writes land one edge after the port shows them.
    );

    rv_operand u_operand
    (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_bus(dec_bus),
        .i_reg1_data(reg1_data),
        .i_reg2_data(reg2_data),
        .o_bus(opr_bus)
    );

    rv_alu u_alu
    (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_bus(opr_bus),
        .o_wb(wb_bus),
        .o_redirect(o_redirect),
        .o_redirect_pc(o_redirect_pc)
    );

    assign o_wb_valid = wb_bus.valid;
    assign o_wb_rd    = wb_bus.rd;
    assign o_wb_data  = wb_bus.data;

endmodule

// File: sim/tb_rv_exec.sv
`timescale 1ns/1ns

module tb_rv_exec;

    localparam int period  = 100;
    localparam int n_instr = 31 + 62 + 2 + 200 + 40 + 40 + 60 + 20;

    typedef struct packed
    {
        logic                   wb_valid;
        rv_exec_pkg::reg_idx_t  rd;
        rv_exec_pkg::xdata_t    data;
        logic                   redirect;
        rv_exec_pkg::xdata_t    target;
    } expect_t;

    logic                   i_clk;
    logic                   i_arst_n;
    logic                   i_valid;
    logic [31:0]            i_instr;
    rv_exec_pkg::xdata_t    i_pc;
    logic                   o_wb_valid;
    rv_exec_pkg::reg_idx_t  o_wb_rd;
    rv_exec_pkg::xdata_t    o_wb_data;
    logic                   o_redirect;
    rv_exec_pkg::xdata_t    o_redirect_pc;

    rv_exec_pkg::xdata_t    model [32];    // architectural state, x0 never written.
    expect_t                exp_q [$];
    expect_t                cur;
    string                  cur_name;
    logic [31:0]            lfsr_state;

    rv_exec_top dut
    (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_valid(i_valid),
        .i_instr(i_instr),
        .i_pc(i_pc),
        .o_wb_valid(o_wb_valid),
        .o_wb_rd(o_wb_rd),
        .o_wb_data(o_wb_data),
        .o_redirect(o_redirect),
        .o_redirect_pc(o_redirect_pc)
    );

    initial i_clk = 1'b0;
    always #(period / 2) i_clk = ~i_clk;

    task automatic value_error(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("Error %s: expected %h, actual %h", what, expected, actual);
        $display("TB FAILED");
        $fatal(1, "mismatch on %s", what);
    endtask

    task automatic plain_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic rv_exec_pkg::xdata_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic rv_exec_pkg::xdata_t alu_ref(input logic [2:0] f3, input logic alt,
                                                    input rv_exec_pkg::xdata_t a,
                                                    input rv_exec_pkg::xdata_t b);
        case (f3)
        3'b000:  return alt ? (a - b) : (a + b);
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:
        begin
            if (alt)
                return $signed(a) >>> b[4:0];
            else
                return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv_exec_pkg::xdata_t a,
                                        input rv_exec_pkg::xdata_t b);
        case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
        endcase
    endfunction

    // one issue cycle and three idle ones, called on a falling edge.
    task automatic issue(input string name, input logic [31:0] instr,
                         input rv_exec_pkg::xdata_t pc, input expect_t e);
        exp_q.push_back(e);
        cur_name = name;
        i_valid  = 1'b1;
        i_instr  = instr;
        i_pc     = pc;
        @(negedge i_clk);
        i_valid  = 1'b0;
        repeat (2) @(negedge i_clk);
        cur = exp_q.pop_front();    // head is checked on the next rising edge.
        @(negedge i_clk);
        if (e.wb_valid)
            model[e.rd] = e.data;
    endtask

    task automatic run_r(input string name, input logic [2:0] f3, input logic alt,
                         input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        expect_t e;
        e = '{rd != 0, rd, alu_ref(f3, alt, model[rs1], model[rs2]), 1'b0, 32'h0};
        issue(name, {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011}, take_bits(30) << 2, e);
    endtask

    task automatic run_i(input string name, input logic [2:0] f3, input logic alt,
                         input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        expect_t e;
        e = '{rd != 0, rd, alu_ref(f3, alt, model[rs1], sext12(imm)), 1'b0, 32'h0};
        issue(name, {imm, rs1, f3, rd, 7'b0010011}, take_bits(30) << 2, e);
    endtask

    task automatic run_upper(input logic auipc, input logic [4:0] rd, input logic [19:0] imm);
        rv_exec_pkg::xdata_t pc;
        expect_t             e;
        pc = take_bits(30) << 2;
        e  = '{rd != 0, rd, (auipc ? pc : 32'h0) + {imm, 12'h0}, 1'b0, 32'h0};
        issue(auipc ? "auipc" : "lui", {imm, rd, auipc ? 7'b0010111 : 7'b0110111}, pc, e);
    endtask

    task automatic run_jump();
        rv_exec_pkg::xdata_t pc;
        rv_exec_pkg::xdata_t off;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [11:0]         imm;
        expect_t             e;
        pc  = take_bits(30) << 2;
        rd  = 5'(take_bits(5));
        rs1 = 5'(take_bits(5));
        imm = 12'(take_bits(12));
        if (take_bits(1))
        begin
            off = take_bits(20) << 1;
            off = {{11{off[20]}}, off[20:0]};
            e   = '{rd != 0, rd, pc + 4, 1'b1, pc + off};
            issue("jal", {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111}, pc, e);
        end
        else
        begin
            e = '{rd != 0, rd, pc + 4, 1'b1, (model[rs1] + sext12(imm)) & 32'hffff_fffe};
            issue("jalr", {imm, rs1, 3'b000, rd, 7'b1100111}, pc, e);
        end
    endtask

    task automatic run_branch();
        rv_exec_pkg::xdata_t pc;
        rv_exec_pkg::xdata_t off;
        logic [2:0]          f3;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        expect_t             e;
        pc  = take_bits(30) << 2;
        f3  = 3'(take_bits(3));
        if (f3 == 3'd2 || f3 == 3'd3)
            f3 = f3 + 3'd4;     // no branch uses funct3 2 or 3.
        rs1 = 5'(take_bits(5));
        rs2 = (take_bits(2) == 0) ? rs1 : 5'(take_bits(5));
        off = take_bits(12) << 1;
        off = {{19{off[12]}}, off[12:0]};
        e   = '{1'b0, 5'd0, 32'h0, branch_ref(f3, model[rs1], model[rs2]), pc + off};
        issue("branch", {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011},
              pc, e);
    endtask

    task automatic run_arith();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'(take_bits(3));
        alt = take_bits(1) && (f3 == 3'b000 || f3 == 3'b101);
        imm = 12'(take_bits(12));
        if (take_bits(1))
            run_r("alu_reg", f3, alt, 5'(take_bits(5)), 5'(take_bits(5)), 5'(take_bits(5)));
        else
        begin
            if (f3 == 3'b001 || f3 == 3'b101)
                imm = {1'b0, alt && f3[2], 5'b0, imm[4:0]};   // shift form.
            run_i("alu_imm", f3, alt && f3[2], 5'(take_bits(5)), 5'(take_bits(5)), imm);
        end
    endtask

    a_quiet: assert property (@(posedge i_clk)
        !$past(i_valid, 3) |-> (!o_wb_valid && !o_redirect))
        else plain_error("writeback or redirect seen with no instruction issued 3 cycles before");
    a_wb_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> ##3 (o_wb_valid == cur.wb_valid))
        else value_error({cur_name, " wb_valid"}, 32'(cur.wb_valid), 32'($sampled(o_wb_valid)));
    a_wb_rd: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> ##3 (!cur.wb_valid || o_wb_rd == cur.rd))
        else value_error({cur_name, " wb_rd"}, 32'(cur.rd), 32'($sampled(o_wb_rd)));
    a_wb_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> ##3 (!cur.wb_valid || o_wb_data == cur.data))
        else value_error({cur_name, " wb_data"}, cur.data, $sampled(o_wb_data));
    a_redirect: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> ##3 (o_redirect == cur.redirect))
        else value_error({cur_name, " redirect"}, 32'(cur.redirect), 32'($sampled(o_redirect)));
    a_target: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> ##3 (!cur.redirect || o_redirect_pc == cur.target))
        else value_error({cur_name, " redirect_pc"}, cur.target, $sampled(o_redirect_pc));

    initial
    begin
        #((n_instr * 4 + 200) * period);
        plain_error("watchdog expired before all instructions were checked");
    end

    initial
    begin
        i_arst_n   = 1'b0;
        i_valid    = 1'b0;
        i_instr    = '0;
        i_pc       = '0;
        cur        = '0;
        cur_name   = "reset";
        lfsr_state = 32'h2f4b_6d3c;
        for (int r = 0; r < 32; r++)
            model[r] = '0;
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;
        @(negedge i_clk);
        for (int r = 1; r < 32; r++)
            run_r("clear_check", 3'b000, 1'b0, 5'(r), 5'(r), 5'd0);
        for (int r = 1; r < 32; r++)
        begin
            run_upper(1'b0, 5'(r), 20'(take_bits(20)));
            run_i("addi_seed", 3'b000, 1'b0, 5'(r), 5'(r), 12'(take_bits(12)));
        end
        run_i("write_x0", 3'b000, 1'b0, 5'd0, 5'd5, 12'h123);
        run_r("read_x0", 3'b000, 1'b0, 5'd1, 5'd0, 5'd0);
        repeat (200) run_arith();
        repeat (40) run_upper(1'(take_bits(1)), 5'(take_bits(5)), 20'(take_bits(20)));
        repeat (40) run_jump();
        repeat (60) run_branch();
        for (int k = 0; k < 20; k++)
        begin
            if (k[0])
                issue("store_word", {7'(take_bits(7)), 10'(take_bits(10)), 3'b010,
                      5'(take_bits(5)), 7'b0100011}, take_bits(30) << 2, '0);
            else
                issue("load_word", {12'(take_bits(12)), 5'(take_bits(5)), 3'b010,
                      5'(take_bits(5)), 7'b0000011}, take_bits(30) << 2, '0);
        end
        repeat (4) @(negedge i_clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+hw
hw/rv_exec_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_operand.sv
hw/rv_alu.sv
hw/rv_exec_top.sv
sim/tb_rv_exec.sv
